//--- src/snd_pkg.sv
// shared types and memory map of the sound bus fabric, referenced by scoped name from each module
`default_nettype none

package snd_pkg;

    typedef logic [15:0] snd_addr_t;   // sound CPU address
    typedef logic [7:0]  snd_data_t;
    typedef logic [16:0] rom_addr_t;   // {page[2:0], offset[13:0]}
    typedef logic [3:0]  bank_t;       // only bits 2:0 reach the ROM

    // one sound CPU access, held stable while req is high
    typedef struct packed {
        snd_addr_t addr;
        snd_data_t wdata;
        logic      wr;
    } snd_bus_req_t;

    typedef enum logic [2:0] {
        REGION_ROM,
        REGION_RAM,
        REGION_CHIP,
        REGION_LATCH,
        REGION_BANK,
        REGION_NONE
    } snd_region_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        ACK,
        RELEASE
    } bus_state_t;

    // each region runs from its base up to the next base minus one
    // ROM starts at 0000, so it ends just below RAM_BASE
    localparam snd_addr_t RAM_BASE      = 16'hc000;  // C000-DFFF
    localparam snd_addr_t CHIP_BASE     = 16'he000;  // E000-EFFF, FM and PCM window
    localparam snd_addr_t LATCH_BASE    = 16'hf000;  // F000-F7FF
    localparam snd_addr_t BANK_BASE     = 16'hf800;  // F800-FBFF
    localparam snd_addr_t UNMAPPED_BASE = 16'hfc00;  // FC00-FFFF

    localparam snd_data_t OPEN_BUS = 8'hff;  // chip window, bank and unmapped reads

endpackage

`default_nettype wire

//--- src/snd_bus_ctrl.sv
// sound bus control: decodes the memory map, runs the req/ack handshake and owns the bank register
`timescale 1ns/1ns
`default_nettype none

module snd_bus_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  snd_pkg::snd_bus_req_t sbus,
    output logic                  ack,
    output snd_pkg::snd_data_t    rdata,
    output logic                  rom_start,
    output logic [2:0]            rom_page,
    input  logic                  rom_done,
    input  snd_pkg::snd_data_t    rom_q,
    output logic                  ram_we,
    input  snd_pkg::snd_data_t    ram_rdata,
    output logic [1:0]            latch_sel,
    output logic                  latch_we,
    output logic                  latch_rd,
    input  snd_pkg::snd_data_t    latch_q,
    output logic                  nmi_clr
);

    snd_pkg::bus_state_t  state;
    snd_pkg::snd_region_t region;   // decoded when the request is accepted
    snd_pkg::bank_t       bank;
    logic                 wr_q;     // access direction, kept past the fall of req
    logic                 rom_rd;
    logic                 data_ready;

    function automatic snd_pkg::snd_region_t decode(input snd_pkg::snd_addr_t a);
        if (a < snd_pkg::RAM_BASE) begin
            return snd_pkg::REGION_ROM;
        end else if (a < snd_pkg::CHIP_BASE) begin
            return snd_pkg::REGION_RAM;
        end else if (a < snd_pkg::LATCH_BASE) begin
            return snd_pkg::REGION_CHIP;
        end else if (a < snd_pkg::BANK_BASE) begin
            return snd_pkg::REGION_LATCH;
        end else if (a < snd_pkg::UNMAPPED_BASE) begin
            return snd_pkg::REGION_BANK;
        end
        return snd_pkg::REGION_NONE;
    endfunction

    assign rom_rd     = (region == snd_pkg::REGION_ROM) && !wr_q;
    assign data_ready = !rom_rd || rom_done;   // ROM reads wait for the port

    // lower 32kB is fixed, pages 0 and 1; the upper window follows the bank
    assign rom_page = sbus.addr[15] ? bank[2:0] : {2'b00, sbus.addr[14]};

    // strobes come out of the ACCESS cycle
    assign rom_start = (state == snd_pkg::ACCESS) && rom_rd;
    assign ram_we    = (state == snd_pkg::ACCESS) && (region == snd_pkg::REGION_RAM) && wr_q;
    assign latch_we  = (state == snd_pkg::ACCESS) && (region == snd_pkg::REGION_LATCH) && wr_q;

    // read side effect of the latch lands once the master has let go of req
    assign latch_rd = (state == snd_pkg::RELEASE) && !req &&
                      (region == snd_pkg::REGION_LATCH) && !wr_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= snd_pkg::IDLE;
            region    <= snd_pkg::REGION_NONE;
            wr_q      <= 1'b0;
            latch_sel <= 2'd0;
            ack       <= 1'b0;
            bank      <= '0;
            nmi_clr   <= 1'b0;
        end else begin
            case (state)
                snd_pkg::IDLE: begin
                    if (req) begin
                        region    <= decode(sbus.addr);
                        wr_q      <= sbus.wr;
                        latch_sel <= sbus.addr[1:0];
                        state     <= snd_pkg::ACCESS;
                    end
                end
                snd_pkg::ACCESS: begin
                    if (region == snd_pkg::REGION_BANK && wr_q) begin
                        {nmi_clr, bank} <= sbus.wdata[4:0];  // bit 4 holds the NMI clear
                    end
                    state <= snd_pkg::ACK;
                end
                snd_pkg::ACK: begin
                    if (data_ready) begin
                        ack   <= 1'b1;
                        state <= snd_pkg::RELEASE;
                    end
                end
                snd_pkg::RELEASE: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= snd_pkg::IDLE;
                    end
                end
                default: state <= snd_pkg::IDLE;
            endcase
        end
    end

    // read data is sampled together with the rise of ack
    always_ff @(posedge clk) begin
        if (state == snd_pkg::ACK && data_ready) begin
            case (region)
                snd_pkg::REGION_ROM:   rdata <= rom_q;
                snd_pkg::REGION_RAM:   rdata <= ram_rdata;
                snd_pkg::REGION_LATCH: rdata <= latch_q;
                default:               rdata <= snd_pkg::OPEN_BUS;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/snd_rom_port.sv
// program ROM port: latches the banked address on rom_start and holds rom_cs until rom_ok
`timescale 1ns/1ns
`default_nettype none

module snd_rom_port (
    input  logic               clk,
    input  logic               rst,
    input  logic               rom_start,
    input  logic [2:0]         rom_page,
    input  logic [13:0]        offset,
    output logic               rom_done,
    output snd_pkg::snd_data_t rom_q,
    output snd_pkg::rom_addr_t rom_addr,
    output logic               rom_cs,
    input  snd_pkg::snd_data_t rom_data,
    input  logic               rom_ok
);

    logic hit;   // ROM has answered the pending request

    assign hit = rom_cs && rom_ok;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            rom_done <= 1'b0;
        end else begin
            rom_done <= hit;   // one cycle pulse
            if (rom_start) begin
                rom_cs <= 1'b1;
            end else if (hit) begin
                rom_cs <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rom_start) begin
            rom_addr <= {rom_page, offset};
        end
        if (hit) begin
            rom_q <= rom_data;
        end
    end

endmodule

`default_nettype wire

//--- src/snd_ram.sv
// sound CPU work RAM, single port with registered read, mirrored when RAM_AW is below 13
`timescale 1ns/1ns
`default_nettype none

module snd_ram #(
    parameter int RAM_AW = 13
) (
    input  logic               clk,
    input  logic [RAM_AW-1:0]  addr,
    input  snd_pkg::snd_data_t wdata,
    input  logic               we,
    output snd_pkg::snd_data_t rdata
);

    localparam int DEPTH = 1 << RAM_AW;

    snd_pkg::snd_data_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // read before write on the same address
    always_ff @(posedge clk) begin
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

//--- src/snd_latch_pair.sv
// command and reply latches between main and sound CPU, with the sound interrupt on command 0
`timescale 1ns/1ns
`default_nettype none

module snd_latch_pair (
    input  logic               clk,
    input  logic               rst,
    input  logic [1:0]         main_addr,
    input  snd_pkg::snd_data_t main_dout,
    input  logic               main_we,
    output snd_pkg::snd_data_t pair_dout,
    input  logic [1:0]         latch_sel,
    input  snd_pkg::snd_data_t wdata,
    input  logic               latch_we,
    input  logic               latch_rd,
    output snd_pkg::snd_data_t latch_q,
    output logic               int_n
);

    snd_pkg::snd_data_t cmd   [2];   // main to sound
    snd_pkg::snd_data_t reply [2];   // sound to main
    logic               pending;
    logic               cmd0_wr;
    logic               cmd0_rd;

    assign cmd0_wr = main_we && (main_addr == 2'd0);
    assign cmd0_rd = latch_rd && (latch_sel == 2'd0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd[0]   <= '0;
            cmd[1]   <= '0;
            reply[0] <= '0;
            reply[1] <= '0;
            pending  <= 1'b0;
        end else begin
            if (main_we && !main_addr[1]) begin
                cmd[main_addr[0]] <= main_dout;
            end
            if (latch_we && latch_sel[1]) begin
                reply[latch_sel[0]] <= wdata;
            end
            // a new command wins over an acknowledge in the same cycle
            if (cmd0_wr) begin
                pending <= 1'b1;
            end else if (cmd0_rd) begin
                pending <= 1'b0;
            end
        end
    end

    assign int_n = !pending;

    // sound side reads back its own replies at 2 and 3
    assign latch_q = latch_sel[1] ? reply[latch_sel[0]] : cmd[latch_sel[0]];

    assign pair_dout = main_addr[1] ? reply[main_addr[0]] : 8'h00;

endmodule

`default_nettype wire

//--- src/snd_nmi_edge.sv
// NMI source: latches a rising edge of the FM interrupt, held off while nmi_clr is set
`timescale 1ns/1ns
`default_nettype none

module snd_nmi_edge (
    input  logic clk,
    input  logic rst,
    input  logic fm_irq,
    input  logic nmi_clr,
    output logic nmi_n
);

    logic irq_d;
    logic nmi_flag;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            irq_d    <= 1'b0;
            nmi_flag <= 1'b0;
        end else begin
            irq_d <= fm_irq;
            if (nmi_clr) begin
                nmi_flag <= 1'b0;
            end else if (fm_irq && !irq_d) begin
                nmi_flag <= 1'b1;   // rising edge
            end
        end
    end

    assign nmi_n = !(nmi_flag && !nmi_clr);

endmodule

`default_nettype wire

//--- src/snd_subsys.sv
// top of the sound board bus fabric, connects bus control to ROM port, RAM, latches and NMI logic
`timescale 1ns/1ns
`default_nettype none

module snd_subsys #(
    parameter int RAM_AW = 13
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  req,
    input  snd_pkg::snd_bus_req_t sbus,
    output logic                  ack,
    output snd_pkg::snd_data_t    rdata,
    input  logic [1:0]            main_addr,
    input  snd_pkg::snd_data_t    main_dout,
    input  logic                  main_we,
    output snd_pkg::snd_data_t    pair_dout,
    output logic                  int_n,
    input  logic                  fm_irq,
    output logic                  nmi_n,
    output snd_pkg::rom_addr_t    rom_addr,
    output logic                  rom_cs,
    input  snd_pkg::snd_data_t    rom_data,
    input  logic                  rom_ok
);

    logic               rom_start;
    logic [2:0]         rom_page;
    logic               rom_done;
    snd_pkg::snd_data_t rom_q;
    logic               ram_we;
    snd_pkg::snd_data_t ram_rdata;
    logic [1:0]         latch_sel;
    logic               latch_we;
    logic               latch_rd;
    snd_pkg::snd_data_t latch_q;
    logic               nmi_clr;

    snd_bus_ctrl ctrl_i (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .sbus      (sbus),
        .ack       (ack),
        .rdata     (rdata),
        .rom_start (rom_start),
        .rom_page  (rom_page),
        .rom_done  (rom_done),
        .rom_q     (rom_q),
        .ram_we    (ram_we),
        .ram_rdata (ram_rdata),
        .latch_sel (latch_sel),
        .latch_we  (latch_we),
        .latch_rd  (latch_rd),
        .latch_q   (latch_q),
        .nmi_clr   (nmi_clr)
    );

    snd_rom_port rom_i (
        .clk       (clk),
        .rst       (rst),
        .rom_start (rom_start),
        .rom_page  (rom_page),
        .offset    (sbus.addr[13:0]),
        .rom_done  (rom_done),
        .rom_q     (rom_q),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok)
    );

    snd_ram #(.RAM_AW(RAM_AW)) ram_i (
        .clk   (clk),
        .addr  (sbus.addr[RAM_AW-1:0]),
        .wdata (sbus.wdata),
        .we    (ram_we),
        .rdata (ram_rdata)
    );

    snd_latch_pair latch_i (
        .clk       (clk),
        .rst       (rst),
        .main_addr (main_addr),
        .main_dout (main_dout),
        .main_we   (main_we),
        .pair_dout (pair_dout),
        .latch_sel (latch_sel),
        .wdata     (sbus.wdata),
        .latch_we  (latch_we),
        .latch_rd  (latch_rd),
        .latch_q   (latch_q),
        .int_n     (int_n)
    );

    snd_nmi_edge nmi_i (
        .clk     (clk),
        .rst     (rst),
        .fm_irq  (fm_irq),
        .nmi_clr (nmi_clr),
        .nmi_n   (nmi_n)
    );

endmodule

`default_nettype wire

//--- test/snd_subsys_asserts.sv
// handshake and reset checks on the sound subsystem, bound to its top level
`timescale 1ns/1ns
`default_nettype none

module snd_subsys_asserts (
    input logic clk,
    input logic rst,
    input logic req,
    input logic ack,
    input logic rom_cs,
    input logic int_n,
    input logic nmi_n
);

    // ack only answers a request that was up when it rose
    ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack) |-> $past(req))
        else $error("ack rose without a pending req");

    ack_held: assert property (@(posedge clk) disable iff (rst) (ack && req) |=> ack)
        else $error("ack dropped while req was still high");

    rom_idle: assert property (@(posedge clk) disable iff (rst) !req |-> !rom_cs)
        else $error("rom_cs high with no bus request");

    reset_values: assert property (@(posedge clk) rst |=> (!ack && !rom_cs && int_n && nmi_n))
        else $error("outputs left their reset values during reset");

endmodule

bind snd_subsys snd_subsys_asserts asserts_i (
    .clk    (clk),
    .rst    (rst),
    .req    (req),
    .ack    (ack),
    .rom_cs (rom_cs),
    .int_n  (int_n),
    .nmi_n  (nmi_n)
);

`default_nettype wire

//--- test/snd_subsys_tb.sv
// testbench for the sound subsystem: plays the sound CPU, the main CPU, the FM chip and the ROM
`timescale 1ns/1ns
`default_nettype none

module snd_subsys_tb;

    localparam int TEST_CYCLES     = 60 * 12 + 280;  // ~60 accesses of up to 12 cycles, plus gaps
    localparam int WATCHDOG_CYCLES = 20 * TEST_CYCLES;

    logic                  clk;
    logic                  rst;
    logic                  req;
    snd_pkg::snd_bus_req_t sbus;
    logic                  ack;
    snd_pkg::snd_data_t    rdata;
    logic [1:0]            main_addr;
    snd_pkg::snd_data_t    main_dout;
    logic                  main_we;
    snd_pkg::snd_data_t    pair_dout;
    logic                  int_n;
    logic                  fm_irq;
    logic                  nmi_n;
    snd_pkg::rom_addr_t    rom_addr;
    logic                  rom_cs;
    snd_pkg::snd_data_t    rom_data;
    logic                  rom_ok;

    int              errors;
    int              checks;
    int              tests_run;
    int              tests_failed;
    int              mark;
    string           cur_test;

    snd_subsys #(.RAM_AW(13)) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    // ROM contents are a function of the byte address
    function automatic snd_pkg::snd_data_t rom_byte(input snd_pkg::rom_addr_t a);
        return a[7:0] ^ a[16:9];
    endfunction

    // ROM model, answers each rom_cs after 0 to 5 cycles
    initial begin
        int delay;
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(posedge clk);
            #1;
            if (rom_cs) begin
                delay = $urandom % 6;
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                rom_data = rom_byte(rom_addr);
                rom_ok   = 1'b1;
                @(posedge clk);
                #1;
                rom_ok = 1'b0;
            end
        end
    end

    task automatic check_byte(input string name, input snd_pkg::snd_data_t got,
                              input snd_pkg::snd_data_t exp);
        checks++;
        assert (got == exp) else begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        mark     = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == mark) begin
            $display("test %-8s ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %-8s failed with %0d errors", cur_test, errors - mark);
        end
    endtask

    task automatic wait_ack(input logic level);
        while (ack !== level) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one four-phase access, inputs change 1 ns after the clock edge
    task automatic bus_access(input snd_pkg::snd_addr_t a, input snd_pkg::snd_data_t d,
                              input logic wr, output snd_pkg::snd_data_t q);
        @(posedge clk);
        #1;
        sbus.addr  = a;
        sbus.wdata = d;
        sbus.wr    = wr;
        req        = 1'b1;
        wait_ack(1'b1);
        q   = rdata;
        req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic bus_write(input snd_pkg::snd_addr_t a, input snd_pkg::snd_data_t d);
        snd_pkg::snd_data_t unused;
        bus_access(a, d, 1'b1, unused);
    endtask

    task automatic expect_read(input snd_pkg::snd_addr_t a, input snd_pkg::snd_data_t exp);
        snd_pkg::snd_data_t q;
        bus_access(a, 8'h00, 1'b0, q);
        check_byte($sformatf("rdata at %h", a), q, exp);
    endtask

    task automatic set_bank(input snd_pkg::snd_data_t d);
        bus_write(16'hf800, d);
    endtask

    task automatic main_write(input logic [1:0] a, input snd_pkg::snd_data_t d);
        @(posedge clk);
        #1;
        main_addr = a;
        main_dout = d;
        main_we   = 1'b1;
        @(posedge clk);
        #1;
        main_we = 1'b0;
    endtask

    task automatic check_pair(input logic [1:0] a, input snd_pkg::snd_data_t exp);
        @(posedge clk);
        #1;
        main_addr = a;
        #10;
        check_byte($sformatf("pair_dout at %0h", a), pair_dout, exp);
    endtask

    // fm_irq low long enough to be seen, then a rising edge
    task automatic fm_rise();
        @(posedge clk);
        #1;
        fm_irq = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        fm_irq = 1'b1;
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset();
        start_test("reset");
        check_bit("ack", ack, 1'b0);
        check_bit("rom_cs", rom_cs, 1'b0);
        check_bit("int_n", int_n, 1'b1);
        check_bit("nmi_n", nmi_n, 1'b1);
        expect_read(16'h8000, rom_byte({3'd0, 14'h0000}));   // bank is 0 after reset
        end_test();
    endtask

    task automatic test_rom_bank();
        start_test("rom_bank");
        expect_read(16'h0000, rom_byte({3'd0, 14'h0000}));
        expect_read(16'h4000, rom_byte({3'd1, 14'h0000}));
        set_bank(8'h02);
        repeat (4) expect_read(16'h8123, rom_byte({3'd2, 14'h0123}));
        set_bank(8'h05);
        repeat (4) expect_read(16'h8123, rom_byte({3'd5, 14'h0123}));
        end_test();
    endtask

    task automatic test_ram();
        snd_pkg::snd_addr_t addrs [16];
        snd_pkg::snd_data_t vals  [16];
        start_test("ram");
        for (int i = 0; i < 16; i++) begin
            // one address per 512 byte slice, so no two collide
            addrs[i] = snd_pkg::snd_addr_t'(32'hc000 + i * 32'h200 + ($urandom & 32'h1ff));
            vals[i]  = snd_pkg::snd_data_t'($urandom);
            bus_write(addrs[i], vals[i]);
        end
        for (int i = 0; i < 16; i++) begin
            expect_read(addrs[i], vals[i]);
        end
        expect_read(16'he123, 8'hff);   // FM and PCM window
        expect_read(16'hfc10, 8'hff);
        expect_read(16'hf800, 8'hff);
        end_test();
    endtask

    task automatic test_cmd_latch();
        start_test("cmd");
        main_write(2'd0, 8'h5a);
        check_bit("int_n", int_n, 1'b0);
        expect_read(16'hf000, 8'h5a);
        check_bit("int_n", int_n, 1'b1);
        main_write(2'd1, 8'hc3);
        check_bit("int_n", int_n, 1'b1);
        main_write(2'd0, 8'ha5);   // interrupt pending again
        check_bit("int_n", int_n, 1'b0);
        expect_read(16'hf001, 8'hc3);
        check_bit("int_n", int_n, 1'b0);   // latch 1 leaves it pending
        expect_read(16'hf000, 8'ha5);
        check_bit("int_n", int_n, 1'b1);
        end_test();
    endtask

    task automatic test_reply();
        start_test("reply");
        bus_write(16'hf002, 8'h3c);
        bus_write(16'hf003, 8'h96);
        check_pair(2'd2, 8'h3c);
        check_pair(2'd3, 8'h96);
        check_pair(2'd0, 8'h00);
        end_test();
    endtask

    task automatic test_nmi();
        start_test("nmi");
        fm_rise();
        check_bit("nmi_n", nmi_n, 1'b0);
        set_bank(8'h10);
        check_bit("nmi_n", nmi_n, 1'b1);
        fm_rise();
        check_bit("nmi_n", nmi_n, 1'b1);   // held off by nmi_clr
        set_bank(8'h00);
        check_bit("nmi_n", nmi_n, 1'b1);
        fm_rise();
        check_bit("nmi_n", nmi_n, 1'b0);
        end_test();
    endtask

    initial begin
        void'($urandom(32'h97af_b976));
        rst          = 1'b1;
        req          = 1'b0;
        sbus         = '0;
        main_addr    = 2'd0;
        main_dout    = 8'h00;
        main_we      = 1'b0;
        fm_irq       = 1'b0;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset();
        test_rom_bank();
        test_ram();
        test_cmd_latch();
        test_reply();
        test_nmi();

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- snd_subsys.f
src/snd_pkg.sv
src/snd_bus_ctrl.sv
src/snd_rom_port.sv
src/snd_ram.sv
src/snd_latch_pair.sv
src/snd_nmi_edge.sv
src/snd_subsys.sv
test/snd_subsys_asserts.sv
test/snd_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the sound subsystem testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

{ verilator --binary --timing --assert -f snd_subsys.f \
    --top-module snd_subsys_tb -o snd_subsys_sim \
    && ./obj_dir/snd_subsys_sim; } > "$LOG" 2>&1

grep -qxF '*** TEST PASSED ***' "$LOG" \
    && echo "simulation passed, log in $LOG" \
    || { echo "simulation failed, log in $LOG"; exit 1; }
